//--- kb_pkg.sv
`default_nettype none

package kb_pkg;

	localparam int CAND_DEPTH = 2; // buffer slots, also starting credits
	localparam int CAND_PTR_W = $clog2(CAND_DEPTH);
	localparam int CAND_CNT_W = $clog2(CAND_DEPTH + 1);
	localparam int MD5_STEPS = 64;

	localparam logic [31:0] MD5_INIT_A = 32'h67452301;
	localparam logic [31:0] MD5_INIT_B = 32'hefcdab89;
	localparam logic [31:0] MD5_INIT_C = 32'h98badcfe;
	localparam logic [31:0] MD5_INIT_D = 32'h10325476;

	// additive constants, entry 0 first
	localparam logic [0:63][31:0] MD5_K_TAB = {
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	// rotate amounts repeat every four steps within a round
	localparam logic [0:15][4:0] MD5_S_TAB = {
		5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9, 5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21
	};

	function automatic logic [31:0] MD5_K(input logic [5:0] i);
		return MD5_K_TAB[i];
	endfunction

	function automatic logic [4:0] MD5_S(input logic [5:0] i);
		return MD5_S_TAB[{i[5:4], i[1:0]}]; // round, then position in group of four
	endfunction

	typedef struct packed {
		logic [447:0] kb; // words 0..13, word i at bits 32i+31:32i
		logic [8:0] msg_bits; // message length in bits
		logic [7:0] tag;
	} cand_t;

	typedef struct packed {
		logic [127:0] digest; // {D, C, B, A}
		logic [7:0] tag;
		logic match;
	} result_t;

	typedef enum logic [1:0] {IDLE, LOAD, HASH, REPORT} ctrl_state_e;

	typedef enum logic [1:0] {MD5_IDLE, MD5_RUN, MD5_FIN} md5_state_e;

endpackage

`default_nettype wire

//--- cand_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module cand_buffer import kb_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire cand_t push_data,
	input wire logic pop,
	output logic head_valid,
	output cand_t head,
	output logic credit
);

	cand_t mem [CAND_DEPTH]; // payload store
	logic [CAND_PTR_W-1:0] wr_ptr;
	logic [CAND_PTR_W-1:0] rd_ptr;
	logic [CAND_CNT_W-1:0] count; // occupied slots

	assign head_valid = (count != '0);
	assign head = mem[rd_ptr]; // oldest entry

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop; // one credit back per pop
			if (push) wr_ptr <= (wr_ptr == CAND_PTR_W'(CAND_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop) rd_ptr <= (rd_ptr == CAND_PTR_W'(CAND_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none, or both at once
			endcase
		end
	end

	// sender must hold a credit, so a full buffer never sees a push
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push |-> count != CAND_CNT_W'(CAND_DEPTH));

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop |-> count != '0);

endmodule

`default_nettype wire

//--- md5_core.sv
`timescale 1ns/100ps
`default_nettype none

module md5_core import kb_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic write,
	input wire logic [3:0] addr,
	input wire logic [31:0] data,
	input wire logic start,
	output logic done,
	output logic [127:0] digest
);

	md5_state_e state;
	logic [$clog2(MD5_STEPS)-1:0] step; // 0..63
	logic [31:0] msg [16]; // message words, little-endian as loaded
	logic [31:0] a, b, c, d; // working registers
	logic [31:0] f; // round function output
	logic [3:0] g; // message word index for this step
	logic [3:0] step_lo;
	logic [31:0] sum;
	logic [63:0] rot_dbl; // doubled word for rotate
	logic [31:0] b_next;

	assign digest = {d, c, b, a}; // A in the low word

	always_ff @(posedge clk) begin
		if (write) msg[addr] <= data;
	end

	// one MD5 step, combinational
	always_comb begin
		step_lo = step[3:0];
		case (step[5:4]) // round select
			2'd0: begin
				f = (b & c) | (~b & d);
				g = step_lo;
			end
			2'd1: begin
				f = (d & b) | (~d & c);
				g = step_lo * 4'd5 + 4'd1; // mod 16 by truncation
			end
			2'd2: begin
				f = b ^ c ^ d;
				g = step_lo * 4'd3 + 4'd5;
			end
			default: begin
				f = c ^ (b | ~d);
				g = step_lo * 4'd7;
			end
		endcase
		sum = a + f + MD5_K(step) + msg[g];
		rot_dbl = {sum, sum} << MD5_S(step); // upper half is rotl
		b_next = b + rot_dbl[63:32];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MD5_IDLE;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= (state == MD5_FIN); // registered done after finalize
			case (state)
				MD5_IDLE: begin
					if (start) begin
						state <= MD5_RUN;
						step <= '0;
					end
				end
				MD5_RUN: begin
					step <= step + 1'b1;
					if (step == $bits(step)'(MD5_STEPS - 1)) state <= MD5_FIN;
				end
				default: state <= MD5_IDLE; // FIN lasts one cycle
			endcase
		end
	end

	// working registers, no reset needed
	always_ff @(posedge clk) begin
		case (state)
			MD5_IDLE: begin
				if (start) begin
					a <= MD5_INIT_A;
					b <= MD5_INIT_B;
					c <= MD5_INIT_C;
					d <= MD5_INIT_D;
				end
			end
			MD5_RUN: begin
				a <= d; // rotate the four words
				d <= c;
				c <= b;
				b <= b_next;
			end
			MD5_FIN: begin
				a <= a + MD5_INIT_A; // fold in chaining values
				b <= b + MD5_INIT_B;
				c <= c + MD5_INIT_C;
				d <= d + MD5_INIT_D;
			end
			default: begin
				a <= a;
			end
		endcase
	end

	// message words must stay put while the rounds read them
	a_no_write_in_run: assert property (@(posedge clk) disable iff (rst)
		write |-> state != MD5_RUN);

endmodule

`default_nettype wire

//--- key_check.sv
`timescale 1ns/100ps
`default_nettype none

module key_check import kb_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic head_valid,
	input wire cand_t head,
	input wire logic [127:0] target,
	input wire logic md5_done,
	input wire logic [127:0] md5_digest,
	output logic pop,
	output logic md5_write,
	output logic [3:0] md5_addr,
	output logic [31:0] md5_data,
	output logic md5_start,
	output logic result_valid,
	output result_t result
);

	ctrl_state_e state;
	logic [3:0] cnt; // word being written
	cand_t cand_q; // candidate under test

	assign pop = (state == IDLE) && head_valid;
	assign md5_write = (state == LOAD);
	assign md5_addr = cnt;

	// block build, words 14 and 15 carry the length
	always_comb begin
		case (cnt)
			4'd14: md5_data = {23'd0, cand_q.msg_bits};
			4'd15: md5_data = 32'd0;
			default: md5_data = cand_q.kb[{cnt, 5'd0} +: 32];
		endcase
	end

	// digest stays stable in the core until the next start
	assign result_valid = (state == REPORT);
	assign result.digest = md5_digest;
	assign result.tag = cand_q.tag;
	assign result.match = (md5_digest == target);

	always_ff @(posedge clk) begin
		if (pop) cand_q <= head; // latch on pop
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt <= '0;
			md5_start <= 1'b0;
		end else begin
			md5_start <= 1'b0; // single-cycle pulse
			case (state)
				IDLE: begin
					if (head_valid) begin
						state <= LOAD;
						cnt <= '0;
					end
				end
				LOAD: begin
					cnt <= cnt + 1'b1;
					if (cnt == 4'd15) begin
						md5_start <= 1'b1; // start the cycle after the last word
						state <= HASH;
					end
				end
				HASH: begin
					if (md5_done) state <= REPORT;
				end
				default: state <= IDLE; // REPORT, one compare cycle
			endcase
		end
	end

	// core finishes only on work this controller started
	a_done_in_hash: assert property (@(posedge clk) disable iff (rst)
		md5_done |-> state == HASH);

endmodule

`default_nettype wire

//--- key_check_top.sv
`timescale 1ns/100ps
`default_nettype none

module key_check_top import kb_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic cand_valid,
	input wire cand_t cand,
	input wire logic [127:0] target,
	output logic credit,
	output logic result_valid,
	output result_t result
);

	logic head_valid;
	cand_t head;
	logic pop;
	logic md5_write; // controller to core
	logic [3:0] md5_addr;
	logic [31:0] md5_data;
	logic md5_start;
	logic md5_done; // core to controller
	logic [127:0] md5_digest;

	cand_buffer u_buf (
		.clk(clk),
		.rst(rst),
		.push(cand_valid),
		.push_data(cand),
		.pop(pop),
		.head_valid(head_valid),
		.head(head),
		.credit(credit)
	);

	key_check u_ctrl (
		.clk(clk),
		.rst(rst),
		.head_valid(head_valid),
		.head(head),
		.target(target),
		.md5_done(md5_done),
		.md5_digest(md5_digest),
		.pop(pop),
		.md5_write(md5_write),
		.md5_addr(md5_addr),
		.md5_data(md5_data),
		.md5_start(md5_start),
		.result_valid(result_valid),
		.result(result)
	);

	md5_core u_md5 (
		.clk(clk),
		.rst(rst),
		.write(md5_write),
		.addr(md5_addr),
		.data(md5_data),
		.start(md5_start),
		.done(md5_done),
		.digest(md5_digest)
	);

endmodule

`default_nettype wire

//--- tb_md5_ref.svh
`ifndef TB_MD5_REF_SVH
`define TB_MD5_REF_SVH

// rotate left, amount is 4..23 for every MD5 step
function automatic logic [31:0] rotl32(input logic [31:0] x, input int s);
	return (x << s) | (x >> (32 - s));
endfunction

// MD5 of the single 512-bit block built from one candidate
function automatic logic [127:0] md5_of(input cand_t c);
	logic [31:0] w [16];
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] cc;
	logic [31:0] d;
	logic [31:0] f;
	logic [31:0] sum;
	logic [31:0] tmp;
	int g;
	for (int i = 0; i < 14; i++) begin
		w[i] = c.kb[32*i +: 32]; // word i straight from kb
	end
	w[14] = {23'd0, c.msg_bits}; // length in bits
	w[15] = 32'd0;
	a = MD5_INIT_A;
	b = MD5_INIT_B;
	cc = MD5_INIT_C;
	d = MD5_INIT_D;
	for (int i = 0; i < MD5_STEPS; i++) begin
		if (i < 16) begin
			f = (b & cc) | (~b & d); // F
			g = i;
		end else if (i < 32) begin
			f = (d & b) | (~d & cc); // G
			g = (5 * i + 1) % 16;
		end else if (i < 48) begin
			f = b ^ cc ^ d; // H
			g = (3 * i + 5) % 16;
		end else begin
			f = cc ^ (b | ~d); // I
			g = (7 * i) % 16;
		end
		sum = a + f + MD5_K(6'(i)) + w[g];
		tmp = d;
		d = cc;
		cc = b;
		b = b + rotl32(sum, int'(MD5_S(6'(i))));
		a = tmp;
	end
	return {d + MD5_INIT_D, cc + MD5_INIT_C, b + MD5_INIT_B, a + MD5_INIT_A}; // A lowest
endfunction

// full expected result for one candidate against the current target
function automatic result_t expected_result(input cand_t c, input logic [127:0] tgt);
	result_t r;
	r.digest = md5_of(c);
	r.tag = c.tag;
	r.match = (r.digest == tgt);
	return r;
endfunction

`endif

//--- tb_key_check_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_key_check_top import kb_pkg::*; ();

	localparam int N_RAND = 12; // back-to-back random burst
	localparam int N_MATCH = 6; // random mix with one hit
	localparam int N_BURST = 8; // longer than the buffer
	localparam int N_TOTAL = 2 + N_RAND + N_MATCH + N_BURST + 1;
	localparam int CAND_CYCLES = 84; // pop to result_valid
	localparam logic [127:0] DIGEST_EMPTY = 128'h7e42f8ec_980980e9_04b2008f_d98c1dd4;
	localparam logic [127:0] DIGEST_ABC = 128'h727fe128_7d3f96d6_b04fd23c_98500190;

	logic clk = 1'b0;
	logic rst;
	logic cand_valid;
	cand_t cand;
	logic [127:0] target;
	logic credit;
	logic result_valid;
	result_t result;

	integer seed = 32'hb18e_e69b;
	int credits = CAND_DEPTH; // sender side credit count
	int cycle_cnt = 0;
	int push_cycle = 0; // cycle of the latest drive
	int n_match = 0;
	int stalls = 0; // cycles the driver waited for credit
	result_t exp_q [$]; // expected results, input order
	result_t exp_r;

	`include "tb_md5_ref.svh"

	key_check_top u_dut (
		.clk(clk),
		.rst(rst),
		.cand_valid(cand_valid),
		.cand(cand),
		.target(target),
		.credit(credit),
		.result_valid(result_valid),
		.result(result)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run("stopping at first mismatch");
		end
	endtask

	function automatic cand_t random_cand(input logic [7:0] tag);
		cand_t c;
		for (int i = 0; i < 14; i++) begin
			c.kb[32*i +: 32] = $random(seed);
		end
		c.msg_bits = 9'($unsigned($random(seed)) % 441); // 0..440 bits
		c.tag = tag;
		return c;
	endfunction

	function automatic cand_t known_cand(input logic [31:0] w0, input logic [8:0] bits,
			input logic [7:0] tag);
		cand_t c;
		c = '0;
		c.kb[31:0] = w0; // short message plus pad byte in word 0
		c.msg_bits = bits;
		c.tag = tag;
		return c;
	endfunction

	// one cycle of cand_valid per credit spent
	task automatic send_cand(input cand_t c);
		@(posedge clk);
		#1;
		while (credits == 0) begin
			cand_valid = 1'b0; // stalled, no credit
			stalls++;
			@(posedge clk);
			#1;
		end
		cand_valid = 1'b1;
		cand = c;
		credits--;
		exp_q.push_back(expected_result(c, target));
		push_cycle = cycle_cnt;
	endtask

	task automatic release_bus();
		@(posedge clk);
		#1;
		cand_valid = 1'b0;
	endtask

	task automatic wait_idle();
		release_bus();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	// credit returns, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && credit) begin
			if (credits >= CAND_DEPTH)
				abort_run("credit returned while the sender already held every credit");
			else
				credits++;
		end
	end

	// compare each result with the head of the expected queue
	always @(negedge clk) begin
		if (!rst && result_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("result_valid seen with no candidate outstanding");
			end else begin
				exp_r = exp_q.pop_front();
				check_value(result.digest, exp_r.digest, "digest");
				check_value(128'(result.tag), 128'(exp_r.tag), "tag");
				check_value(128'(result.match), 128'(exp_r.match), "match");
				if (result.match) n_match++;
			end
		end
	end

	initial begin
		#(((N_TOTAL + 1) * CAND_CYCLES + 200) * 8); // every candidate, quiet tail, margin
		abort_run("Timeout: results did not arrive in time");
	end

	initial begin
		cand_t hit;
		int base;
		rst = 1'b1;
		cand_valid = 1'b0;
		cand = '0;
		target = DIGEST_ABC; // only the abc vector should match
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		check_value(md5_of(known_cand(32'h00000080, 9'd0, 8'h01)), DIGEST_EMPTY, "ref empty");
		check_value(md5_of(known_cand(32'h80636261, 9'd24, 8'h02)), DIGEST_ABC, "ref abc");
		send_cand(known_cand(32'h00000080, 9'd0, 8'h01)); // empty message
		send_cand(known_cand(32'h80636261, 9'd24, 8'h02)); // "abc"
		wait_idle();
		check_value(128'(n_match), 128'(1), "known vector match count");

		for (int i = 0; i < N_RAND; i++) begin
			send_cand(random_cand(8'(8'h10 + i)));
		end
		wait_idle();
		check_value(128'(credits), 128'(CAND_DEPTH), "credits after random burst");

		hit = random_cand(8'h40);
		target = md5_of(hit); // design idle, safe to move target
		base = n_match;
		for (int i = 0; i < N_MATCH; i++) begin
			if (i == 3) send_cand(hit);
			else send_cand(random_cand(8'(8'h50 + i)));
		end
		wait_idle();
		check_value(128'(n_match - base), 128'(1), "match count in mix");

		base = stalls;
		for (int i = 0; i < N_BURST; i++) begin
			send_cand(random_cand(8'(8'h80 + i)));
		end
		wait_idle();
		check_value(128'(stalls > base), 128'(1), "driver stalled on credit");

		send_cand(random_cand(8'hc0)); // idle design, fixed latency
		release_bus();
		while (!result_valid) @(negedge clk);
		check_value(128'(cycle_cnt - push_cycle), 128'(CAND_CYCLES + 1), "latency");

		wait_idle();
		repeat (CAND_CYCLES + 4) @(posedge clk); // a duplicate would surface here
		check_value(128'(credits), 128'(CAND_DEPTH), "credits at end");
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- key_check_top.f
+incdir+.
kb_pkg.sv
cand_buffer.sv
md5_core.sv
key_check.sv
key_check_top.sv
tb_key_check_top.sv

//--- Makefile
TOP = tb_key_check_top

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): key_check_top.f kb_pkg.sv cand_buffer.sv md5_core.sv key_check.sv \
		key_check_top.sv tb_key_check_top.sv tb_md5_ref.svh
	verilator --binary --timing --assert -Wno-fatal -f key_check_top.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
